//--- sources.f
rtl/sort_types_pkg.sv
rtl/merge_ctrl_pkg.sv
rtl/working_ram.sv
rtl/chunk_reader.sv
rtl/merge_core.sv
rtl/merge_writeback.sv
rtl/merging_unit.sv
tb/merging_unit_tb.sv

//--- Makefile
# Verilator build and run for the merge-sort unit testbench

SOURCES := $(shell cat sources.f)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source file changes
obj_dir/Vmerging_unit_tb: sources.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module merging_unit_tb -f sources.f

# The run passes only if the log holds the pass message
run: obj_dir/Vmerging_unit_tb
	./obj_dir/Vmerging_unit_tb > sim.log 2>&1; cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/merging_unit_tb.sv
// Self-checking testbench for the merge-sort unit.
// Each table entry gives a list length and a value mask. The list is made of
// random words, presorted per chunk, fed in one word per cycle, and the output
// is compared against a full ascending sort of the same words.

module merging_unit_tb
    import sort_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LEN   = 32;
    localparam int CHUNK     = 8;
    localparam int NUM_CASES = 7;

    // Lengths and value masks of the test lists, a small mask forces duplicates
    localparam int    CASE_LEN  [NUM_CASES] = '{8, 16, 32, 13, 27, 20, 1};
    localparam word_t CASE_MASK [NUM_CASES] = '{16'hffff, 16'hffff, 16'hffff,
                                                16'hffff, 16'h00ff, 16'h0003, 16'hffff};

    logic  clock;
    logic  rst_n;
    logic  in_valid;
    word_t in_data;
    logic  in_last;
    logic  busy;
    logic  out_valid;
    word_t out_data;
    logic  out_last;

    word_t scratch  [MAX_LEN];
    word_t stim     [MAX_LEN];
    word_t expected [MAX_LEN];

    int errors;
    int case_errors;
    int cases_ok;

    merging_unit #(
        .MAX_SORT_LENGTH(MAX_LEN),
        .BASE_CHUNK_SIZE(CHUNK)
    ) u_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_last   (in_last),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    initial begin
        clock = 1'b0;
    end

    always #20 clock = ~clock;

    task automatic log_error(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        errors++;
        case_errors++;
    endtask

    // Insertion sort of one slice of the scratch array, ascending
    task automatic sort_scratch(input int first, input int count);
        word_t key;
        int    j;
        for (int i = first + 1; i < first + count; i++) begin
            key = scratch[i];
            j = i - 1;
            while (j >= first && scratch[j] > key) begin
                scratch[j + 1] = scratch[j];
                j--;
            end
            scratch[j + 1] = key;
        end
    endtask

    // Stimulus is sorted per chunk, the expected list is sorted as a whole
    task automatic build_case(input int c);
        int len;
        len = CASE_LEN[c];
        for (int i = 0; i < len; i++) begin
            scratch[i] = word_t'($urandom) & CASE_MASK[c];
        end
        for (int first = 0; first < len; first += CHUNK) begin
            sort_scratch(first, (len - first < CHUNK) ? len - first : CHUNK);
        end
        for (int i = 0; i < len; i++) begin
            stim[i] = scratch[i];
        end
        sort_scratch(0, len);
        for (int i = 0; i < len; i++) begin
            expected[i] = scratch[i];
        end
    endtask

    task automatic send_list(input int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clock);
            in_valid <= 1'b1;
            in_data  <= stim[i];
            in_last  <= (i == len - 1);
            @(negedge clock);
            if (busy || out_valid) begin
                log_error("busy or out_valid is high while the list is loading");
            end
        end
        @(posedge clock);
        in_valid <= 1'b0;
        in_data  <= '0;
        in_last  <= 1'b0;
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            if (busy || out_valid) begin
                log_error("busy or out_valid is high while the unit is idle");
            end
        end
    endtask

    task automatic run_case(input int c);
        int len;
        int got;
        bit last_seen;
        len = CASE_LEN[c];
        got = 0;
        last_seen = 1'b0;
        case_errors = 0;
        build_case(c);
        send_list(len);
        // busy must hold from the cycle after in_last until out_last
        while (!last_seen) begin
            @(negedge clock);
            if (!busy) begin
                log_error("busy is low while the list is being sorted");
            end
            if (out_valid) begin
                if (got >= len) begin
                    log_error($sformatf("case %0d sent more than %0d words", c, len));
                end else if (out_data !== expected[got]) begin
                    log_error($sformatf("case %0d word %0d is %h, expected %h",
                                        c, got, out_data, expected[got]));
                end
                if (out_last) begin
                    last_seen = 1'b1;
                    if (got != len - 1) begin
                        log_error($sformatf("case %0d out_last on word %0d of %0d",
                                            c, got + 1, len));
                    end
                end
                got++;
            end
        end
        @(negedge clock);
        if (busy) begin
            log_error("busy is still high in the cycle after out_last");
        end
        $display("case %0d: %0d words in, %0d words out, %0d errors",
                 c, len, got, case_errors);
        if (case_errors == 0) begin
            cases_ok++;
        end
    endtask

    initial begin
        void'($urandom(32'h5d10_a0ae));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_last  = 1'b0;
        errors   = 0;
        cases_ok = 0;
        case_errors = 0;
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        for (int c = 0; c < NUM_CASES; c++) begin
            check_idle(4);
            run_case(c);
        end
        check_idle(4);
        $display("%0d cases run, %0d clean, %0d with errors, %0d errors in total",
                 NUM_CASES, cases_ok, NUM_CASES - cases_ok, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Budget of eight cycles per word and pass for every case, plus reset and a margin
    initial begin : watchdog
        int limit;
        limit = 16 + 500;
        for (int c = 0; c < NUM_CASES; c++) begin
            limit += CASE_LEN[c] * ((CASE_LEN[c] + CHUNK - 1) / CHUNK + 1) * 8;
        end
        repeat (limit) @(posedge clock);
        $display("Timeout: the DUT hung and the run did not finish within %0d cycles",
                 limit);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- rtl/merging_unit.sv
// Merge-sort unit for lists made of presorted chunks of BASE_CHUNK_SIZE words.
// Feed one word per in_valid with in_last on the final one; busy stays high
// until the sorted list has left on out_valid/out_data with out_last.

module merging_unit
    import sort_types_pkg::*;
    import merge_ctrl_pkg::*;
#(
    parameter int MAX_SORT_LENGTH = 32,
    parameter int BASE_CHUNK_SIZE = 8
) (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  in_valid,
    input  word_t in_data,
    input  logic  in_last,
    output logic  busy,
    output logic  out_valid,
    output word_t out_data,
    output logic  out_last
);

    localparam len_t CHUNK_LEN = len_t'(BASE_CHUNK_SIZE);

    merge_state_t state;

    // The fill count doubles as the list length for the rest of the sort
    len_t fill_count;
    len_t prefix_len;
    len_t remain_len;
    len_t first_len;
    len_t next_len;
    len_t out_count;
    logic final_pass;
    logic reader_start;
    logic copy_start;

    addr_t ram_addr_a;
    word_t ram_wdata_a;
    logic  ram_we_a;
    word_t ram_rdata_a;
    addr_t ram_addr_b;
    word_t ram_rdata_b;

    word_t head_a;
    word_t head_b;
    logic  head_valid_a;
    logic  head_valid_b;
    logic  exhausted_a;
    logic  exhausted_b;
    logic  take_a;
    logic  take_b;
    addr_t read_addr_a;
    word_t merged;
    logic  merged_valid;
    logic  merge_done;

    addr_t wb_addr;
    word_t wb_data;
    logic  wb_enable;
    logic  copy_done;

    assign first_len    = (fill_count < CHUNK_LEN) ? fill_count : CHUNK_LEN;
    assign next_len     = (remain_len < CHUNK_LEN) ? remain_len : CHUNK_LEN;
    // Nothing is left once this pass has taken its chunk
    assign final_pass   = (remain_len == next_len);
    assign reader_start = (state == merge_reading);
    assign busy         = (state != merge_idle);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= merge_idle;
            fill_count <= '0;
            prefix_len <= '0;
            remain_len <= '0;
            out_count  <= '0;
            copy_start <= 1'b0;
        end else begin
            copy_start <= 1'b0;
            case (state)
                merge_idle: begin
                    out_count <= '0;
                    if (in_valid) begin
                        fill_count <= fill_count + 1'b1;
                        if (in_last) begin
                            state <= merge_loading;
                        end
                    end
                end
                merge_loading: begin
                    prefix_len <= first_len;
                    remain_len <= fill_count - first_len;
                    state      <= merge_reading;
                end
                merge_reading: begin
                    state <= merge_merging;
                end
                merge_merging: begin
                    if (out_valid) begin
                        out_count <= out_count + 1'b1;
                    end
                    if (out_last) begin
                        fill_count <= '0;
                        state      <= merge_idle;
                    end else if (merge_done && !final_pass) begin
                        copy_start <= 1'b1;
                        state      <= merge_writeback;
                    end
                end
                merge_writeback: begin
                    // The prefix grows by the chunk that was just merged in
                    if (copy_done) begin
                        prefix_len <= prefix_len + next_len;
                        remain_len <= remain_len - next_len;
                        state      <= merge_reading;
                    end
                end
                default: begin
                    state <= merge_idle;
                end
            endcase
        end
    end

    // Port a belongs to the input side, reader a or the writeback buffer
    always_comb begin
        ram_addr_a  = '0;
        ram_wdata_a = wb_data;
        ram_we_a    = 1'b0;
        case (state)
            merge_idle: begin
                ram_addr_a  = addr_t'(fill_count);
                ram_wdata_a = in_data;
                ram_we_a    = in_valid;
            end
            merge_reading, merge_merging: begin
                ram_addr_a = read_addr_a;
            end
            merge_writeback: begin
                ram_addr_a = wb_addr;
                ram_we_a   = wb_enable;
            end
            default: begin
                ram_addr_a = '0;
            end
        endcase
    end

    assign out_valid = merged_valid & final_pass & (state == merge_merging);
    assign out_data  = merged;
    assign out_last  = out_valid & (out_count == fill_count - 1'b1);

    working_ram #(
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH)
    ) u_working_ram (
        .clock   (clock),
        .addr_a  (ram_addr_a),
        .wdata_a (ram_wdata_a),
        .we_a    (ram_we_a),
        .rdata_a (ram_rdata_a),
        .addr_b  (ram_addr_b),
        .rdata_b (ram_rdata_b)
    );

    chunk_reader u_reader_a (
        .clock      (clock),
        .rst_n      (rst_n),
        .start      (reader_start),
        .base       ('0),
        .length     (prefix_len),
        .take       (take_a),
        .read_addr  (read_addr_a),
        .read_data  (ram_rdata_a),
        .head       (head_a),
        .head_valid (head_valid_a),
        .exhausted  (exhausted_a)
    );

    chunk_reader u_reader_b (
        .clock      (clock),
        .rst_n      (rst_n),
        .start      (reader_start),
        .base       (addr_t'(prefix_len)),
        .length     (next_len),
        .take       (take_b),
        .read_addr  (ram_addr_b),
        .read_data  (ram_rdata_b),
        .head       (head_b),
        .head_valid (head_valid_b),
        .exhausted  (exhausted_b)
    );

    merge_core u_merge_core (
        .clock        (clock),
        .rst_n        (rst_n),
        .head_a       (head_a),
        .head_b       (head_b),
        .valid_a      (head_valid_a),
        .valid_b      (head_valid_b),
        .exhausted_a  (exhausted_a),
        .exhausted_b  (exhausted_b),
        .take_a       (take_a),
        .take_b       (take_b),
        .merged       (merged),
        .merged_valid (merged_valid),
        .merge_done   (merge_done)
    );

    // Words of a non-final pass go to the writeback buffer
    merge_writeback #(
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH)
    ) u_merge_writeback (
        .clock        (clock),
        .rst_n        (rst_n),
        .merged       (merged),
        .merged_valid (merged_valid & !final_pass),
        .copy_start   (copy_start),
        .write_addr   (wb_addr),
        .write_data   (wb_data),
        .write_enable (wb_enable),
        .copy_done    (copy_done)
    );

    a_fill_in_range: assert property (@(posedge clock) disable iff (!rst_n)
        fill_count <= len_t'(MAX_SORT_LENGTH));

endmodule

//--- rtl/merge_writeback.sv
// Collects the words of one merge pass and then copies them back into the
// working RAM from address zero. Pulse copy_start after the pass; copy_done
// follows the last write.

module merge_writeback
    import sort_types_pkg::*;
    import merge_ctrl_pkg::*;
#(
    parameter int MAX_SORT_LENGTH = 32
) (
    input  logic  clock,
    input  logic  rst_n,
    input  word_t merged,
    input  logic  merged_valid,
    input  logic  copy_start,
    output addr_t write_addr,
    output word_t write_data,
    output logic  write_enable,
    output logic  copy_done
);

    localparam int IDX_WIDTH = $clog2(MAX_SORT_LENGTH);

    writeback_state_t state;

    word_t buffer [MAX_SORT_LENGTH];
    len_t  count;
    addr_t copy_addr;

    assign write_addr   = copy_addr;
    assign write_data   = buffer[copy_addr[IDX_WIDTH-1:0]];
    assign write_enable = (state == wb_copy);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state     <= wb_collect;
            count     <= '0;
            copy_addr <= '0;
            copy_done <= 1'b0;
        end else begin
            copy_done <= 1'b0;
            case (state)
                wb_collect: begin
                    if (merged_valid) begin
                        count <= count + 1'b1;
                    end
                    if (copy_start) begin
                        state     <= wb_copy;
                        copy_addr <= '0;
                    end
                end
                wb_copy: begin
                    // One write per cycle until the collected count is used up
                    if (copy_addr == addr_t'(count - 1'b1)) begin
                        state     <= wb_collect;
                        count     <= '0;
                        copy_addr <= '0;
                        copy_done <= 1'b1;
                    end else begin
                        copy_addr <= copy_addr + 1'b1;
                    end
                end
                default: begin
                    state <= wb_collect;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == wb_collect && merged_valid) begin
            buffer[count[IDX_WIDTH-1:0]] <= merged;
        end
    end

endmodule

//--- rtl/merge_core.sv
// Compares the heads of two chunk readers and emits the smaller word each time.
// merged/merged_valid carry the result one cycle after the take, and
// merge_done pulses once when both readers have run dry.

module merge_core
    import sort_types_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  word_t head_a,
    input  word_t head_b,
    input  logic  valid_a,
    input  logic  valid_b,
    input  logic  exhausted_a,
    input  logic  exhausted_b,
    output logic  take_a,
    output logic  take_b,
    output word_t merged,
    output logic  merged_valid,
    output logic  merge_done
);

    logic side_a_ready;
    logic side_b_ready;
    logic can_decide;
    logic both_exhausted;
    logic both_exhausted_q;

    // A side is settled once it shows a head or has nothing left
    assign side_a_ready = valid_a | exhausted_a;
    assign side_b_ready = valid_b | exhausted_b;
    assign can_decide   = side_a_ready & side_b_ready & (valid_a | valid_b);

    // Equal heads go to side a, which keeps the merge stable
    assign take_a = can_decide & valid_a & (!valid_b | (head_a <= head_b));
    assign take_b = can_decide & valid_b & !take_a;

    assign both_exhausted = exhausted_a & exhausted_b;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            merged_valid     <= 1'b0;
            merge_done       <= 1'b0;
            both_exhausted_q <= 1'b0;
        end else begin
            merged_valid     <= take_a | take_b;
            // The rising edge of both_exhausted marks the end of the pass
            merge_done       <= both_exhausted & !both_exhausted_q;
            both_exhausted_q <= both_exhausted;
        end
    end

    always_ff @(posedge clock) begin
        if (take_a) begin
            merged <= head_a;
        end else if (take_b) begin
            merged <= head_b;
        end
    end

    // The done pulse comes in the cycle right after the last merged word
    a_done_after_last_word: assert property (@(posedge clock) disable iff (!rst_n)
        merge_done |-> $past(merged_valid));

endmodule

//--- rtl/chunk_reader.sv
// Walks one ascending chunk of the working RAM and exposes its smallest
// unread word as a head. Pulse start with base and length, then pulse take
// to consume the head; the next head follows two cycles later.

module chunk_reader
    import sort_types_pkg::*;
    import merge_ctrl_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  start,
    input  addr_t base,
    input  len_t  length,
    input  logic  take,
    output addr_t read_addr,
    input  word_t read_data,
    output word_t head,
    output logic  head_valid,
    output logic  exhausted
);

    reader_state_t state;

    // Address of the next unread word and how many words remain unread
    addr_t next_addr;
    len_t  remain;

    // The address goes out in the same cycle as start or take, so the RAM
    // result is ready in the following fetch cycle
    assign read_addr  = start ? base : next_addr;
    assign head_valid = (state == reader_head_valid);
    assign exhausted  = (state == reader_exhausted);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state     <= reader_idle;
            next_addr <= '0;
            remain    <= '0;
        end else if (start) begin
            next_addr <= base + 1'b1;
            if (length == '0) begin
                state  <= reader_exhausted;
                remain <= '0;
            end else begin
                state  <= reader_fetch;
                remain <= length - 1'b1;
            end
        end else begin
            case (state)
                reader_fetch: begin
                    state <= reader_head_valid;
                end
                reader_head_valid: begin
                    if (take) begin
                        if (remain == '0) begin
                            state <= reader_exhausted;
                        end else begin
                            state     <= reader_fetch;
                            next_addr <= next_addr + 1'b1;
                            remain    <= remain - 1'b1;
                        end
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == reader_fetch) begin
            head <= read_data;
        end
    end

    // The merge core may only consume a head that is on display
    a_take_needs_head: assert property (@(posedge clock) disable iff (!rst_n)
        take |-> head_valid);

endmodule

//--- rtl/working_ram.sv
// Working storage for the list being sorted.
// Port a reads and writes, port b only reads, both with one cycle of read latency.

module working_ram
    import sort_types_pkg::*;
#(
    parameter int MAX_SORT_LENGTH = 32
) (
    input  logic  clock,
    input  addr_t addr_a,
    input  word_t wdata_a,
    input  logic  we_a,
    output word_t rdata_a,
    input  addr_t addr_b,
    output word_t rdata_b
);

    localparam int IDX_WIDTH = $clog2(MAX_SORT_LENGTH);

    word_t mem [MAX_SORT_LENGTH];

    // Only the low address bits select a location
    logic [IDX_WIDTH-1:0] idx_a;
    logic [IDX_WIDTH-1:0] idx_b;

    assign idx_a = addr_a[IDX_WIDTH-1:0];
    assign idx_b = addr_b[IDX_WIDTH-1:0];

    // A read on port a during a write returns the old contents
    always_ff @(posedge clock) begin
        if (we_a) begin
            mem[idx_a] <= wdata_a;
        end
        rdata_a <= mem[idx_a];
    end

    always_ff @(posedge clock) begin
        rdata_b <= mem[idx_b];
    end

    a_write_in_range: assert property (@(posedge clock)
        we_a |-> (addr_a < addr_t'(MAX_SORT_LENGTH)));

endmodule

//--- rtl/merge_ctrl_pkg.sv
// State encodings for the control FSMs of the merging unit.
// The sequencer, the chunk readers and the writeback buffer each use one enum.

package merge_ctrl_pkg;

    // Pass sequencer in the top level
    typedef enum logic [2:0] {
        merge_idle,
        merge_loading,
        merge_reading,
        merge_merging,
        merge_writeback
    } merge_state_t;

    typedef enum logic [1:0] {
        reader_idle,
        reader_fetch,
        reader_head_valid,
        reader_exhausted
    } reader_state_t;

    typedef enum logic {
        wb_collect,
        wb_copy
    } writeback_state_t;

endpackage

//--- rtl/sort_types_pkg.sv
// Word and address types shared by the merge-sort datapath.
// Import into any module that carries list words, RAM addresses or lengths.

package sort_types_pkg;

    // One list element
    localparam int WORD_WIDTH = 16;
    typedef logic [WORD_WIDTH-1:0] word_t;

    // Addresses and lengths share one width so a length can serve as a base address
    localparam int ADDR_WIDTH = 16;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Count of words in a chunk or pass, zero means empty
    typedef logic [ADDR_WIDTH-1:0] len_t;

endpackage
